/* csr_pkg.sv */
// shared CSR definitions with addresses, widths, operation encoding,
// request bundle and performance event strobes
package csr_pkg;

  //////////////////////////////////////////////////
  // widths and basic types
  //////////////////////////////////////////////////

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [5:0]  cause_t;     // bit 5 marks an interrupt
  typedef logic [23:0] tvec_t;      // upper part of the trap vector

  localparam int N_PERF_EVENTS = 8;
  localparam int PCCR_IDX_W    = 5;  // counter index inside 780h..79Fh

  typedef logic [N_PERF_EVENTS-1:0] perf_sel_t;  // one bit per event

  // CSR access operation
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  //////////////////////////////////////////////////
  // addresses and field positions
  //////////////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;
  localparam csr_addr_t CSR_PCER      = 12'h7A0;
  localparam csr_addr_t CSR_PCMR      = 12'h7A1;
  localparam csr_addr_t CSR_PCCR_BASE = 12'h780;
  localparam csr_addr_t CSR_PCCR_ALL  = 12'h79F;  // writes every counter

  localparam int         MSTATUS_MIE_BIT   = 3;
  localparam int         MSTATUS_MPIE_BIT  = 7;
  localparam int         MSTATUS_MPP_LSB   = 11;
  localparam logic [1:0] MSTATUS_MPP_VALUE = 2'b11;  // machine mode only

  localparam logic [1:0] MTVEC_MODE = 2'b01;
  localparam logic [1:0] PCMR_RESET = 2'b11;  // enabled and saturating

  // access request as seen by both register blocks
  typedef struct packed {
    csr_addr_t addr;
    csr_data_t wdata;  // data with set/clear already applied
    logic      we;
    csr_op_e   op;     // raw operation
  } csr_req_t;

  // event strobes with cycle in the lsb so it lands on counter 0
  typedef struct packed {
    logic branch_taken;
    logic jump;
    logic store;
    logic load;
    logic imiss;
    logic ld_stall;
    logic instr;
    logic cycle;
  } perf_events_t;

endpackage

/* csr_access_unit.sv */
// CSR access unit with read data select, set/clear merge and write strobe
module csr_access_unit (
  input  logic               csr_access_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_data_t csr_wdata_i,
  input  csr_pkg::csr_op_e   csr_op_i,
  input  csr_pkg::csr_data_t trap_rdata_i,
  input  csr_pkg::csr_data_t perf_rdata_i,
  input  logic               perf_hit_i,
  output csr_pkg::csr_req_t  req_o,
  output csr_pkg::csr_data_t csr_rdata_o
);
  import csr_pkg::*;

  logic      perf_sel;
  csr_data_t rdata_sel;
  csr_data_t wdata_merged;
  logic      we;

  //////////////////////////////////////////////////
  // read data
  //////////////////////////////////////////////////

  // perf block only claims an address during a real access
  assign perf_sel  = csr_access_i & perf_hit_i;
  assign rdata_sel = perf_sel ? perf_rdata_i : trap_rdata_i;

  assign csr_rdata_o = rdata_sel;

  //////////////////////////////////////////////////
  // write data
  //////////////////////////////////////////////////

  always_comb begin
    wdata_merged = csr_wdata_i;
    we           = 1'b1;

    unique case (csr_op_i)
      CSR_OP_WRITE: wdata_merged = csr_wdata_i;
      CSR_OP_SET:   wdata_merged = csr_wdata_i | rdata_sel;
      CSR_OP_CLEAR: wdata_merged = (~csr_wdata_i) & rdata_sel;
      CSR_OP_NONE: begin
        wdata_merged = csr_wdata_i;
        we           = 1'b0;  // read only
      end
      default: ;
    endcase
  end

  assign req_o = '{
    addr:  csr_addr_i,
    wdata: wdata_merged,
    we:    we,
    op:    csr_op_i
  };

endmodule

/* csr_trap_regs.sv */
// machine trap state with mstatus, mepc, mcause, trap entry and mret,
// plus the read-only mtvec and mhartid
module csr_trap_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  csr_pkg::csr_req_t  req_i,
  input  logic [3:0]         core_id_i,
  input  logic [5:0]         cluster_id_i,
  input  logic [30:0]        boot_addr_i,
  input  csr_pkg::csr_data_t pc_if_i,
  input  csr_pkg::csr_data_t pc_id_i,
  input  csr_pkg::csr_data_t pc_ex_i,
  input  logic               csr_save_if_i,
  input  logic               csr_save_id_i,
  input  logic               csr_save_ex_i,
  input  logic               csr_save_cause_i,
  input  logic               csr_restore_mret_i,
  input  csr_pkg::cause_t    csr_cause_i,
  output csr_pkg::csr_data_t rdata_o,
  output csr_pkg::csr_data_t mepc_o,
  output csr_pkg::tvec_t     mtvec_o,
  output logic               m_irq_enable_o
);
  import csr_pkg::*;

  logic      mie_q, mie_n;
  logic      mpie_q, mpie_n;
  csr_data_t mepc_q, mepc_n;
  cause_t    mcause_q, mcause_n;
  csr_data_t exception_pc;
  tvec_t     mtvec;

  assign mtvec = boot_addr_i[30:7];  // upper bits of {boot_addr, 0}

  //////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    case (req_i.addr)
      CSR_MSTATUS: begin
        rdata_o[MSTATUS_MIE_BIT]        = mie_q;
        rdata_o[MSTATUS_MPIE_BIT]       = mpie_q;
        rdata_o[MSTATUS_MPP_LSB +: 2]   = MSTATUS_MPP_VALUE;
      end
      CSR_MTVEC:   rdata_o = {mtvec, 6'h0, MTVEC_MODE};
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = {mcause_q[5], 26'h0, mcause_q[4:0]};
      CSR_MHARTID: rdata_o = {21'h0, cluster_id_i, 1'b0, core_id_i};
      default: ;
    endcase
  end

  // PC to save defaults to the ID stage
  always_comb begin
    exception_pc = pc_id_i;
    if (csr_save_if_i)
      exception_pc = pc_if_i;
    else if (csr_save_ex_i)
      exception_pc = pc_ex_i;
    else if (csr_save_id_i)
      exception_pc = pc_id_i;
  end

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    mie_n    = mie_q;
    mpie_n   = mpie_q;
    mepc_n   = mepc_q;
    mcause_n = mcause_q;

    if (req_i.we) begin
      case (req_i.addr)
        CSR_MSTATUS: begin
          mie_n  = req_i.wdata[MSTATUS_MIE_BIT];
          mpie_n = req_i.wdata[MSTATUS_MPIE_BIT];
        end
        CSR_MEPC:   mepc_n   = req_i.wdata;
        CSR_MCAUSE: mcause_n = {req_i.wdata[31], req_i.wdata[4:0]};
        default: ;
      endcase
    end

    // trap controller overrides any CSR write
    if (csr_save_cause_i) begin
      mpie_n   = mie_q;
      mie_n    = 1'b0;
      mepc_n   = exception_pc;
      mcause_n = csr_cause_i;
    end else if (csr_restore_mret_i) begin
      mie_n  = mpie_q;
      mpie_n = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_n;
      mpie_q   <= mpie_n;
      mepc_q   <= mepc_n;
      mcause_q <= mcause_n;
    end
  end

  assign mepc_o         = mepc_q;
  assign mtvec_o        = mtvec;
  assign m_irq_enable_o = mie_q;  // always in machine mode

endmodule

/* csr_perf_counters.sv */
// performance counters with event qualification, PCER/PCMR and one
// saturating counter per event
module csr_perf_counters (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               csr_access_i,
  input  csr_pkg::csr_req_t  req_i,
  input  logic               id_valid_i,
  input  logic               is_decoding_i,
  input  logic               ld_stall_i,
  input  logic               imiss_i,
  input  logic               pc_set_i,
  input  logic               mem_load_i,
  input  logic               mem_store_i,
  input  logic               jump_i,
  input  logic               branch_i,
  input  logic               branch_taken_i,
  output csr_pkg::csr_data_t rdata_o,
  output logic               hit_o
);
  import csr_pkg::*;

  perf_events_t                    events;
  logic                            id_valid_q;
  perf_sel_t                       inc, inc_q;
  perf_sel_t                       pcer_q, pcer_n;
  logic [1:0]                      pcmr_q, pcmr_n;
  csr_data_t [N_PERF_EVENTS-1:0]   cnt_q, cnt_n;
  logic                            is_pcer, is_pcmr, is_pccr, pccr_all;
  logic [PCCR_IDX_W-1:0]           pccr_idx;

  //////////////////////////////////////////////////
  // event strobes
  //////////////////////////////////////////////////

  assign events.cycle        = 1'b1;
  assign events.instr        = id_valid_i & is_decoding_i;
  assign events.ld_stall     = ld_stall_i & id_valid_q;
  assign events.imiss        = imiss_i & ~pc_set_i;  // no jump/branch refetch
  assign events.load         = mem_load_i;
  assign events.store        = mem_store_i;
  assign events.jump         = jump_i & id_valid_q;
  assign events.branch_taken = branch_i & branch_taken_i & id_valid_q;

  assign inc = perf_sel_t'(events) & pcer_q & {N_PERF_EVENTS{pcmr_q[0]}};

  //////////////////////////////////////////////////
  // address decode and read
  //////////////////////////////////////////////////

  always_comb begin
    is_pcer  = 1'b0;
    is_pcmr  = 1'b0;
    is_pccr  = 1'b0;
    pccr_all = 1'b0;
    pccr_idx = req_i.addr[PCCR_IDX_W-1:0];
    rdata_o  = '0;
    if (csr_access_i) begin
      if (req_i.addr == CSR_PCER) begin
        is_pcer                      = 1'b1;
        rdata_o[N_PERF_EVENTS-1:0]   = pcer_q;
      end
      if (req_i.addr == CSR_PCMR) begin
        is_pcmr      = 1'b1;
        rdata_o[1:0] = pcmr_q;
      end
      if (req_i.addr[11:PCCR_IDX_W] == CSR_PCCR_BASE[11:PCCR_IDX_W]) begin
        is_pccr  = 1'b1;
        pccr_all = (req_i.addr == CSR_PCCR_ALL);
        if (pccr_idx < N_PERF_EVENTS)
          rdata_o = cnt_q[pccr_idx];  // 79Fh itself reads zero
      end
    end
  end

  assign hit_o = is_pcer | is_pcmr | is_pccr;

  //////////////////////////////////////////////////
  // register updates
  //////////////////////////////////////////////////

  // PCER/PCMR take the merged data with set/clear already applied
  assign pcer_n = (is_pcer && req_i.we) ? req_i.wdata[N_PERF_EVENTS-1:0] : pcer_q;
  assign pcmr_n = (is_pcmr && req_i.we) ? req_i.wdata[1:0] : pcmr_q;

  always_comb begin
    for (int i = 0; i < N_PERF_EVENTS; i++) begin
      cnt_n[i] = cnt_q[i];
      // hold at all-ones when saturating
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1]))
        cnt_n[i] = cnt_q[i] + 32'd1;
      // a CSR write beats the increment
      if (is_pccr && req_i.we && (pccr_all || pccr_idx == PCCR_IDX_W'(i))) begin
        unique case (req_i.op)
          CSR_OP_SET:   cnt_n[i] = cnt_q[i] | req_i.wdata;
          CSR_OP_CLEAR: cnt_n[i] = cnt_q[i] & req_i.wdata;  // wdata = ~data & rdata
          default:      cnt_n[i] = req_i.wdata;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= PCMR_RESET;
      cnt_q      <= '0;
    end else begin
      id_valid_q <= id_valid_i;
      inc_q      <= inc;
      pcer_q     <= pcer_n;
      pcmr_q     <= pcmr_n;
      cnt_q      <= cnt_n;
    end
  end

endmodule

/* csr_file.sv */
// machine-mode CSR file top with access unit, trap registers and perf counters
module csr_file (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [3:0]         core_id_i,
  input  logic [5:0]         cluster_id_i,
  input  logic [30:0]        boot_addr_i,
  input  logic               csr_access_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_data_t csr_wdata_i,
  input  csr_pkg::csr_op_e   csr_op_i,
  output csr_pkg::csr_data_t csr_rdata_o,
  input  csr_pkg::csr_data_t pc_if_i,
  input  csr_pkg::csr_data_t pc_id_i,
  input  csr_pkg::csr_data_t pc_ex_i,
  input  logic               csr_save_if_i,
  input  logic               csr_save_id_i,
  input  logic               csr_save_ex_i,
  input  logic               csr_save_cause_i,
  input  logic               csr_restore_mret_i,
  input  csr_pkg::cause_t    csr_cause_i,
  output csr_pkg::csr_data_t mepc_o,
  output csr_pkg::tvec_t     mtvec_o,
  output logic               m_irq_enable_o,
  input  logic               id_valid_i,
  input  logic               is_decoding_i,
  input  logic               ld_stall_i,
  input  logic               imiss_i,
  input  logic               pc_set_i,
  input  logic               mem_load_i,
  input  logic               mem_store_i,
  input  logic               jump_i,
  input  logic               branch_i,
  input  logic               branch_taken_i
);
  import csr_pkg::*;

  csr_req_t  req;
  csr_data_t trap_rdata;
  csr_data_t perf_rdata;
  logic      perf_hit;

  csr_access_unit u_access (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_op_i     (csr_op_i),
    .trap_rdata_i (trap_rdata),
    .perf_rdata_i (perf_rdata),
    .perf_hit_i   (perf_hit),
    .req_o        (req),
    .csr_rdata_o  (csr_rdata_o)
  );

  csr_trap_regs u_trap (
    .clk                (clk),
    .rst_n              (rst_n),
    .req_i              (req),
    .core_id_i          (core_id_i),
    .cluster_id_i       (cluster_id_i),
    .boot_addr_i        (boot_addr_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .pc_ex_i            (pc_ex_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_save_ex_i      (csr_save_ex_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_cause_i        (csr_cause_i),
    .rdata_o            (trap_rdata),
    .mepc_o             (mepc_o),
    .mtvec_o            (mtvec_o),
    .m_irq_enable_o     (m_irq_enable_o)
  );

  csr_perf_counters u_perf (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_access_i   (csr_access_i),
    .req_i          (req),
    .id_valid_i     (id_valid_i),
    .is_decoding_i  (is_decoding_i),
    .ld_stall_i     (ld_stall_i),
    .imiss_i        (imiss_i),
    .pc_set_i       (pc_set_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i),
    .jump_i         (jump_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i),
    .rdata_o        (perf_rdata),
    .hit_o          (perf_hit)
  );

endmodule

/* tb_csr_file.sv */
// testbench for the CSR file with test file reader, stimulus tasks,
// read data, mepc, mtvec and interrupt enable checks and a cycle timeout
module tb_csr_file;
  import csr_pkg::*;

  localparam logic [3:0]  CORE_ID    = 4'h5;
  localparam logic [5:0]  CLUSTER_ID = 6'h2A;
  localparam logic [30:0] BOOT_ADDR  = 31'h1C00_0080;

  typedef enum logic [2:0] {
    KIND_CSR,
    KIND_TRAP,
    KIND_MRET,
    KIND_EVENT,
    KIND_IDLE
  } kind_e;

  typedef struct packed {
    kind_e       kind;
    csr_op_e     op;
    csr_addr_t   addr;
    csr_data_t   data;      // wdata, trap pc or event bits
    logic [1:0]  pc_src;    // 0 if, 1 id, 2 ex
    cause_t      cause;
    logic [15:0] count;     // cycles for event and idle
    csr_data_t   expected;
  } test_t;

  logic clk, rst_n;
  logic [3:0] core_id_i;
  logic [5:0] cluster_id_i;
  logic [30:0] boot_addr_i;
  logic csr_access_i;
  csr_addr_t csr_addr_i;
  csr_data_t csr_wdata_i, csr_rdata_o;
  csr_op_e csr_op_i;
  csr_data_t pc_if_i, pc_id_i, pc_ex_i, mepc_o;
  logic csr_save_if_i, csr_save_id_i, csr_save_ex_i;
  logic csr_save_cause_i, csr_restore_mret_i;
  cause_t csr_cause_i;
  tvec_t mtvec_o;
  logic m_irq_enable_o;
  logic id_valid_i, is_decoding_i, ld_stall_i, imiss_i, pc_set_i;
  logic mem_load_i, mem_store_i, jump_i, branch_i, branch_taken_i;

  test_t       tests[$];
  bit          test_ok;
  int          n_pass = 0;
  int          n_fail = 0;
  int          load_errors = 0;
  int unsigned budget = 0;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;

  csr_file u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  task automatic set_events(input logic [9:0] bits);
    id_valid_i     = bits[0];
    is_decoding_i  = bits[1];
    ld_stall_i     = bits[2];
    imiss_i        = bits[3];
    pc_set_i       = bits[4];
    mem_load_i     = bits[5];
    mem_store_i    = bits[6];
    jump_i         = bits[7];
    branch_i       = bits[8];
    branch_taken_i = bits[9];
  endtask

  task automatic drive_defaults();
    core_id_i          = CORE_ID;
    cluster_id_i       = CLUSTER_ID;
    boot_addr_i        = BOOT_ADDR;
    csr_access_i       = 1'b0;
    csr_addr_i         = '0;
    csr_wdata_i        = '0;
    csr_op_i           = CSR_OP_NONE;
    pc_if_i            = '0;
    pc_id_i            = '0;
    pc_ex_i            = '0;
    csr_save_if_i      = 1'b0;
    csr_save_id_i      = 1'b0;
    csr_save_ex_i      = 1'b0;
    csr_save_cause_i   = 1'b0;
    csr_restore_mret_i = 1'b0;
    csr_cause_i        = '0;
    set_events('0);
  endtask

  task automatic load_tests();
    int               fd;
    int               n;
    logic [8*8-1:0]   word;
    logic [8*256-1:0] rest;
    int unsigned      op, src, count;
    logic [31:0]      addr, data, cause, expected;
    test_t            t;
    fd = $fopen("csr_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open csr_tests.txt");
      load_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", word);
      if (n != 1)
        break;
      if (word == "#") begin
        n = $fgets(rest, fd);  // column description
        continue;
      end
      n = $fscanf(fd, "%d %h %h %d %h %d %h", op, addr, data, src, cause, count, expected);
      if (n != 7) begin
        $display("incomplete test line in csr_tests.txt");
        load_errors++;
        break;
      end
      t.op       = csr_op_e'(op[1:0]);
      t.addr     = addr[11:0];
      t.data     = data;
      t.pc_src   = src[1:0];
      t.cause    = cause[5:0];
      t.count    = count[15:0];
      t.expected = expected;
      if (word == "csr")        t.kind = KIND_CSR;
      else if (word == "trap")  t.kind = KIND_TRAP;
      else if (word == "mret")  t.kind = KIND_MRET;
      else if (word == "event") t.kind = KIND_EVENT;
      else if (word == "idle")  t.kind = KIND_IDLE;
      else begin
        $display("unknown test kind in csr_tests.txt");
        load_errors++;
        continue;
      end
      tests.push_back(t);
    end
    $fclose(fd);
  endtask

  function automatic string kind_name(input kind_e k);
    case (k)
      KIND_CSR:   return "csr";
      KIND_TRAP:  return "trap";
      KIND_MRET:  return "mret";
      KIND_EVENT: return "event";
      default:    return "idle";
    endcase
  endfunction

  //////////////////////////////////////////////////
  // test kinds
  //////////////////////////////////////////////////

  // one access cycle and a read back in the next one
  task automatic access_csr(input test_t t);
    @(posedge clk);
    #1;
    csr_access_i = 1'b1;
    csr_addr_i   = t.addr;
    csr_wdata_i  = t.data;
    csr_op_i     = t.op;
    @(posedge clk);
    #1;
    csr_op_i    = CSR_OP_NONE;
    csr_wdata_i = '0;
    @(negedge clk);
    if (csr_rdata_o !== t.expected) begin
      $display("Fail %0t: csr %h op %0d read %h expected %h",
               $time, t.addr, t.op, csr_rdata_o, t.expected);
      test_ok = 1'b0;
    end
    // mtvec port carries the upper part of the read value
    if (t.addr == CSR_MTVEC && mtvec_o !== t.expected[31:8]) begin
      $display("Fail %0t: mtvec_o %h expected %h",
               $time, mtvec_o, t.expected[31:8]);
      test_ok = 1'b0;
    end
  endtask

  task automatic enter_trap(input test_t t);
    @(posedge clk);
    #1;
    csr_access_i     = 1'b0;
    csr_op_i         = CSR_OP_NONE;
    pc_if_i          = (t.pc_src == 2'd0) ? t.data : ~t.data;  // others get a decoy
    pc_id_i          = (t.pc_src == 2'd1) ? t.data : ~t.data;
    pc_ex_i          = (t.pc_src == 2'd2) ? t.data : ~t.data;
    csr_save_if_i    = (t.pc_src == 2'd0);
    csr_save_id_i    = (t.pc_src == 2'd1);
    csr_save_ex_i    = (t.pc_src == 2'd2);
    csr_save_cause_i = 1'b1;
    csr_cause_i      = t.cause;
    @(posedge clk);
    #1;
    drive_defaults();
    @(negedge clk);
    // a save always drops MIE
    if (mepc_o !== t.expected || m_irq_enable_o !== 1'b0) begin
      $display("Fail %0t: trap mepc %h irq %b expected mepc %h irq 0",
               $time, mepc_o, m_irq_enable_o, t.expected);
      test_ok = 1'b0;
    end
  endtask

  task automatic return_from_trap(input test_t t);
    @(posedge clk);
    #1;
    csr_restore_mret_i = 1'b1;
    @(posedge clk);
    #1;
    csr_restore_mret_i = 1'b0;
    @(negedge clk);
    if (m_irq_enable_o !== t.expected[0]) begin
      $display("Fail %0t: mret irq enable %b expected %b",
               $time, m_irq_enable_o, t.expected[0]);
      test_ok = 1'b0;
    end
  endtask

  task automatic pulse_events(input test_t t);
    repeat (t.count) begin
      @(posedge clk);
      #1;
      set_events(t.data[9:0]);
    end
    @(posedge clk);
    #1;
    set_events('0);
  endtask

  task automatic idle_cycles(input test_t t);
    repeat (t.count) @(posedge clk);
    @(negedge clk);
    if (m_irq_enable_o !== t.expected[0]) begin
      $display("Fail %0t: idle irq enable %b expected %b",
               $time, m_irq_enable_o, t.expected[0]);
      test_ok = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    drive_defaults();
    load_tests();
    if (tests.size() == 0) begin
      $display("no tests found in csr_tests.txt");
      load_errors++;
    end
    foreach (tests[i])
      budget += tests[i].count + 2;  // csr access plus read back
    cycle_limit = (budget + 20) * 2;

    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;

    foreach (tests[i]) begin
      test_ok = 1'b1;
      case (tests[i].kind)
        KIND_CSR:   access_csr(tests[i]);
        KIND_TRAP:  enter_trap(tests[i]);
        KIND_MRET:  return_from_trap(tests[i]);
        KIND_EVENT: pulse_events(tests[i]);
        default:    idle_cycles(tests[i]);
      endcase
      if (test_ok)
        n_pass++;
      else
        n_fail++;
      $display("test %0d %s: %s", i, kind_name(tests[i].kind), test_ok ? "ok" : "FAILED");
    end

    $display("%0d tests, %0d passed, %0d failed, %0d file errors",
             tests.size(), n_pass, n_fail, load_errors);
    if (n_fail == 0 && load_errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* build.f */
csr_pkg.sv
csr_access_unit.sv
csr_trap_regs.sv
csr_perf_counters.sv
csr_file.sv
tb_csr_file.sv

/* csr_tests.txt */
# kind op addr data pc_src cause count expected (op 0 none 1 write 2 set 3 clear, pc_src 0 if 1 id 2 ex)
# event data bits 0 id_valid 1 is_decoding 2 ld_stall 3 imiss 4 pc_set 5 load 6 store 7 jump 8 branch 9 taken
idle  0 000 00000000 0 00 0 00000000
csr   0 300 00000000 0 00 0 00001800
csr   0 341 00000000 0 00 0 00000000
csr   0 342 00000000 0 00 0 00000000
csr   0 7A0 00000000 0 00 0 00000000
csr   0 7A1 00000000 0 00 0 00000003
csr   0 F14 00000000 0 00 0 00000545
csr   0 305 00000000 0 00 0 38000101
csr   1 341 12345678 0 00 0 12345678
csr   2 341 0000F000 0 00 0 1234F678
csr   3 341 00000078 0 00 0 1234F600
csr   0 341 FFFFFFFF 0 00 0 1234F600
csr   1 300 00000080 0 00 0 00001880
csr   2 300 00000008 0 00 0 00001888
csr   3 300 00000080 0 00 0 00001808
idle  0 000 00000000 0 00 1 00000001
trap  0 000 80000100 2 0B 0 80000100
csr   0 342 00000000 0 00 0 0000000B
csr   0 300 00000000 0 00 0 00001880
mret  0 000 00000000 0 00 0 00000001
csr   0 300 00000000 0 00 0 00001888
csr   1 7A0 00000002 0 00 0 00000002
event 0 000 00000003 0 00 5 00000000
idle  0 000 00000000 0 00 2 00000001
csr   0 781 00000000 0 00 0 00000005
csr   0 780 00000000 0 00 0 00000000
csr   1 780 FFFFFFFF 0 00 0 FFFFFFFF
csr   1 7A0 00000001 0 00 0 00000001
idle  0 000 00000000 0 00 3 00000001
csr   0 780 00000000 0 00 0 FFFFFFFF
csr   1 7A1 00000001 0 00 0 00000001
csr   0 780 00000000 0 00 0 00000001
csr   1 7A0 00000000 0 00 0 00000000
csr   1 79F 00000000 0 00 0 00000000
csr   0 780 00000000 0 00 0 00000000
csr   0 781 00000000 0 00 0 00000000
